// ==== Makefile ====
# Verilator simulation of the debug unit

TOP = debugTopTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f project.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) | tee sim.log
	grep -qx "NO ERRORS" sim.log

lint:
	verilator --lint-only --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

// ==== project.f ====
verilog/dbgPkg.sv
verilog/spiByteEngine.sv
verilog/flashLoader.sv
verilog/debugRegs.sv
verilog/memArbiter.sv
verilog/bootRam.sv
verilog/debugTop.sv
testbench/spiFlashModel.sv
testbench/debugTopTb.sv

// ==== testbench/debugTopTb.sv ====
`timescale 1ns/1ps

module debugTopTb import dbgPkg::*; ();

  localparam int          romWords  = 8;
  localparam logic [31:0] flashBase = 32'h0012_3440;
  localparam int          spiDiv    = 2;
  localparam logic [7:0]  mcuType   = 8'h08;
  localparam logic [7:0]  brdVers   = 8'h05;
  localparam logic [7:0]  coreCnt   = 8'h02;
  localparam logic [7:0]  flashSize = 8'h19;

  logic                 clkH;
  logic                 reset;
  logic                 cmdValid;
  logic                 cmdReady;
  dbgOp_t               cmdOp;
  logic [dataWidth-1:0] cmdData;
  logic                 rspValid;
  logic [dataWidth-1:0] rspData;
  logic                 dbgExecEn;
  logic                 dbgResetS;
  logic                 dbgClkHEn;
  logic                 spiSck;
  logic                 spiMosi;
  logic                 spiMiso;
  logic                 spiCsN;

  // Command table
  dbgOp_t               stepOp[$];
  logic [dataWidth-1:0] stepData[$];
  logic [dataWidth-1:0] stepExp[$];
  bit                   stepPoll[$];
  bit                   stepPins[$];
  string                stepName[$];

  dbgOp_t xferOps[$];
  dbgOp_t rspOps[$];
  dbgOp_t lastXferOp = opCpuCtrlWr;
  bit     tableReady = 1'b0;
  int     checkCount = 0;
  int     errCount   = 0;

  debugTop #(
    .romWords  (romWords),
    .flashBase (flashBase),
    .spiDiv    (spiDiv),
    .mcuType   (mcuType),
    .brdVers   (brdVers),
    .coreCnt   (coreCnt)
  ) i_dut (
    .clkH      (clkH),
    .reset     (reset),
    .cmdValid  (cmdValid),
    .cmdReady  (cmdReady),
    .cmdOp     (cmdOp),
    .cmdData   (cmdData),
    .rspValid  (rspValid),
    .rspData   (rspData),
    .dbgExecEn (dbgExecEn),
    .dbgResetS (dbgResetS),
    .dbgClkHEn (dbgClkHEn),
    .spiSck    (spiSck),
    .spiMosi   (spiMosi),
    .spiMiso   (spiMiso),
    .spiCsN    (spiCsN)
  );

  spiFlashModel #(
    .sizeCode (flashSize)
  ) uFlash (
    .sck  (spiSck),
    .mosi (spiMosi),
    .csN  (spiCsN),
    .miso (spiMiso)
  );

  initial begin
    clkH = 1'b0;
    forever #10 clkH = ~clkH;
  end

  // Log accepted commands and the command each response pulse follows
  always @(posedge clkH) begin
    if (!reset && rspValid) begin
      rspOps.push_back(lastXferOp);
    end
    if (!reset && cmdValid && cmdReady) begin
      xferOps.push_back(cmdOp);
      lastXferOp = cmdOp;
    end
  end

  function automatic bit isReadOp(input dbgOp_t op);
    return (op == opStatRd) || (op == opInfoRd) || (op == opMemAddrRd) || (op == opMemDataRd);
  endfunction

  function automatic logic [dataWidth-1:0] statusWord(input logic [2:0] ctrl,
                                                       input logic active,
                                                       input logic [7:0] size);
    logic [dataWidth-1:0] w;
    w        = '0;
    w[2:0]   = ctrl;
    w[4]     = active;
    w[15:8]  = size;
    return w;
  endfunction

  function automatic logic [dataWidth-1:0] infoWord();
    logic [dataWidth-1:0] w;
    w        = '0;
    w[7:0]   = coreCnt;
    w[15:8]  = mcuType;
    w[23:16] = brdVers;
    return w;
  endfunction

  // Byte k of word w is the low byte of flashBase + 8w + k, XOR 5A
  function automatic logic [dataWidth-1:0] flashWord(input int w);
    logic [dataWidth-1:0] word;
    logic [31:0]          a;
    word = '0;
    for (int k = 0; k < 8; k++) begin
      a = flashBase + 32'(8 * w + k);
      word[8*k +: 8] = a[7:0] ^ 8'h5A;
    end
    return word;
  endfunction

  task automatic checkWord(input string name, input logic [dataWidth-1:0] expected,
                           input logic [dataWidth-1:0] actual);
    checkCount = checkCount + 1;
    if (actual !== expected) begin
      errCount = errCount + 1;
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
    end else begin
      $display("PASS %s %h", name, actual);
    end
  endtask

  task automatic checkOp(input string name, input dbgOp_t expected, input dbgOp_t actual);
    checkCount = checkCount + 1;
    if (actual !== expected) begin
      errCount = errCount + 1;
      $display("CHECK FAILED %s expected %s actual %s", name, expected.name(), actual.name());
    end else begin
      $display("PASS %s %s", name, actual.name());
    end
  endtask

  task automatic addStep(input dbgOp_t op, input logic [dataWidth-1:0] data,
                         input logic [dataWidth-1:0] expected, input bit poll,
                         input bit pins, input string name);
    stepOp.push_back(op);
    stepData.push_back(data);
    stepExp.push_back(expected);
    stepPoll.push_back(poll);
    stepPins.push_back(pins);
    stepName.push_back(name);
  endtask

  // Returns 2 ns after the edge where the command transferred
  task automatic sendCmd(input dbgOp_t op, input logic [dataWidth-1:0] data);
    logic accepted;
    cmdOp    = op;
    cmdData  = data;
    cmdValid = 1'b1;
    accepted = 1'b0;
    while (!accepted) begin
      accepted = cmdReady;
      @(posedge clkH);
      #2;
    end
    cmdValid = 1'b0;
  endtask

  task automatic waitResponse(output logic [dataWidth-1:0] data, output int cycles);
    cycles = 0;
    while (rspValid !== 1'b1) begin
      @(posedge clkH);
      #2;
      cycles = cycles + 1;
    end
    data = rspData;
  endtask

  task automatic applyStep(input int i);
    logic [dataWidth-1:0] rsp;
    int                   cycles;
    dbgOp_t               answeredOp;
    bit                   again;
    again      = 1'b1;
    answeredOp = stepOp[i];
    while (again) begin
      sendCmd(stepOp[i], stepData[i]);
      if (xferOps.size() != 1) begin
        errCount = errCount + 1;
        $display("%s: expected one command transfer but saw %0d", stepName[i], xferOps.size());
      end
      xferOps.delete();
      rsp = '0;
      if (isReadOp(stepOp[i])) begin
        waitResponse(rsp, cycles);
        if (cycles != 0 && stepOp[i] != opMemDataRd) begin
          errCount = errCount + 1;
          $display("%s: response came %0d cycles late", stepName[i], cycles);
        end
        if (cmdReady !== 1'b1) begin
          errCount = errCount + 1;
          $display("%s: cmdReady was still low in the response cycle", stepName[i]);
        end
        // One more edge so the pulse is logged
        @(posedge clkH);
        #2;
        answeredOp = rspOps.pop_front();
      end
      again = stepPoll[i] && rsp[4] && (answeredOp == stepOp[i]);
    end
    if (isReadOp(stepOp[i])) begin
      checkOp({stepName[i], " answered command"}, stepOp[i], answeredOp);
      checkWord(stepName[i], stepExp[i], rsp);
    end
    if (stepPins[i]) begin
      checkWord({stepName[i], " pins"}, {61'b0, stepExp[i][2:0]},
                {61'b0, dbgExecEn, dbgResetS, dbgClkHEn});
    end
  endtask

  initial begin : mainSeq
    logic [2:0]               ctrlVal;
    logic [wordAddrWidth-1:0] wordAddr;
    logic [dataWidth-1:0]     memWords [4];
    void'($urandom(32'h58a5));
    reset    = 1'b1;
    cmdValid = 1'b0;
    cmdOp    = opStatRd;
    cmdData  = '0;

    addStep(opStatRd, '0, statusWord(3'b000, 1'b0, 8'h00), 1'b0, 1'b1, "status after reset");
    addStep(opInfoRd, '0, infoWord(), 1'b0, 1'b0, "board info");

    ctrlVal = 3'($urandom);
    addStep(opCpuCtrlWr, {61'b0, ctrlVal}, '0, 1'b0, 1'b0, "cpu control write");
    addStep(opStatRd, '0, statusWord(ctrlVal, 1'b0, 8'h00), 1'b0, 1'b1, "status after control");

    wordAddr = wordAddrWidth'($urandom);
    addStep(opMemAddrWr, {35'b0, wordAddr}, '0, 1'b0, 1'b0, "address write");
    addStep(opMemAddrRd, '0, {35'b0, wordAddr} << 3, 1'b0, 1'b0, "address readback");

    // Boot copy, then read back the whole RAM
    addStep(opLoaderStart, '0, '0, 1'b0, 1'b0, "loader start");
    addStep(opStatRd, '0, statusWord(ctrlVal, 1'b0, flashSize), 1'b1, 1'b0, "status after copy");
    addStep(opMemAddrWr, '0, '0, 1'b0, 1'b0, "address to boot base");
    for (int w = 0; w < romWords; w++) begin
      addStep(opMemDataRd, '0, flashWord(w), 1'b0, 1'b0, $sformatf("boot word %0d", w));
    end

    addStep(opMemAddrWr, 64'd2, '0, 1'b0, 1'b0, "address to block start");
    for (int k = 0; k < 4; k++) begin
      memWords[k] = {$urandom, $urandom};
      addStep(opMemDataWr, memWords[k], '0, 1'b0, 1'b0, $sformatf("block write %0d", k));
    end
    addStep(opMemAddrWr, 64'd2, '0, 1'b0, 1'b0, "address back to block start");
    for (int k = 0; k < 4; k++) begin
      addStep(opMemDataRd, '0, memWords[k], 1'b0, 1'b0, $sformatf("block read %0d", k));
    end

    // Word 3 holds stale data until the second copy lands
    addStep(opMemAddrWr, 64'd3, '0, 1'b0, 1'b0, "address before reload");
    addStep(opLoaderStart, '0, '0, 1'b0, 1'b0, "loader restart");
    addStep(opLoaderStart, '0, '0, 1'b0, 1'b0, "loader start while busy");
    addStep(opMemDataRd, '0, flashWord(3), 1'b0, 1'b0, "read held off by copy");
    addStep(opStatRd, '0, statusWord(ctrlVal, 1'b0, flashSize), 1'b0, 1'b1,
            "status after held read");
    addStep(opMemDataRd, '0, flashWord(4), 1'b0, 1'b0, "read after held read");
    tableReady = 1'b1;

    repeat (2) @(posedge clkH);
    #2;
    reset = 1'b0;
    @(posedge clkH);
    #2;
    checkWord("ports after reset", 64'd10, {60'b0, cmdReady, rspValid, spiCsN, spiSck});

    for (int i = 0; i < stepOp.size(); i++) begin
      applyStep(i);
    end

    if (rspOps.size() != 0) begin
      errCount = errCount + 1;
      $display("%0d response pulses came without a read command", rspOps.size());
    end

    $display("Steps: %0d, checks: %0d, failures: %0d", stepOp.size(), checkCount, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin : watchdog
    int limit;
    wait (tableReady);
    limit = stepOp.size() * 50 + romWords * 8 * 16 * spiDiv + 2000;
    repeat (limit) @(posedge clkH);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// ==== testbench/spiFlashModel.sv ====
`timescale 1ns/1ps

module spiFlashModel #(
  parameter logic [7:0] sizeCode = 8'h19
) (
  input  logic sck,
  input  logic mosi,
  input  logic csN,
  output logic miso
);

  // Codes above 8'h18 need 4 address bytes
  localparam int addrBytes = (sizeCode > 8'h18) ? 4 : 3;

  logic [7:0]  rxShift = 8'h00;
  logic [2:0]  bitCnt  = 3'd0;
  int          byteCnt = 0;
  logic [7:0]  cmd     = 8'h00;
  logic [31:0] addr    = 32'h0;
  logic [7:0]  nextTx  = 8'hFF;
  logic [7:0]  txShift = 8'hFF;
  logic        readOk;

  assign readOk = (cmd == 8'h13 && addrBytes == 4) || (cmd == 8'h03 && addrBytes == 3);
  assign miso   = txShift[7];

  always @(posedge sck or posedge csN) begin
    if (csN) begin
      bitCnt  <= 3'd0;
      byteCnt <= 0;
      cmd     <= 8'h00;
      addr    <= 32'h0;
      nextTx  <= 8'hFF;
    end else begin : rxBit
      logic [7:0]  rxByte;
      logic [31:0] curAddr;
      rxByte  = {rxShift[6:0], mosi};
      rxShift <= rxByte;
      bitCnt  <= bitCnt + 3'd1;
      if (bitCnt == 3'd7) begin
        byteCnt <= byteCnt + 1;
        if (byteCnt == 0) begin
          cmd    <= rxByte;
          nextTx <= (rxByte == 8'h9F) ? 8'hEF : 8'hFF;
        end else if (cmd == 8'h9F) begin
          if (byteCnt == 1) begin
            nextTx <= 8'h40;
          end else if (byteCnt == 2) begin
            nextTx <= sizeCode;
          end else begin
            nextTx <= 8'hFF;
          end
        end else if (readOk) begin
          curAddr = addr;
          if (byteCnt <= addrBytes) begin
            curAddr = {addr[23:0], rxByte};
          end
          // Data starts right after the last address byte
          if (byteCnt >= addrBytes) begin
            nextTx <= curAddr[7:0] ^ 8'h5A;
            curAddr = curAddr + 32'd1;
          end
          addr <= curAddr;
        end else begin
          nextTx <= 8'hFF;
        end
      end
    end
  end

  // Mode 0 shifts the next bit out on the falling edge
  always @(negedge sck or posedge csN) begin
    if (csN) begin
      txShift <= 8'hFF;
    end else if (bitCnt == 3'd0) begin
      txShift <= nextTx;
    end else begin
      txShift <= {txShift[6:0], 1'b1};
    end
  end

endmodule

// ==== verilog/bootRam.sv ====
`timescale 1ns/1ps

module bootRam import dbgPkg::*; #(
  parameter int romWords = 16
) (
  input  logic                     clkH,
  input  logic                     en,
  input  logic                     write,
  input  logic [wordAddrWidth-1:0] addr,
  input  logic [dataWidth-1:0]     wrData,
  output logic [dataWidth-1:0]     rdData
);

  localparam int idxW = (romWords > 1) ? $clog2(romWords) : 1;

  logic [dataWidth-1:0] mem [romWords];
  logic                 inRange;

  assign inRange = (addr < wordAddrWidth'(romWords));

  // Out of range reads return zero
  always_ff @(posedge clkH) begin
    if (en) begin
      if (write) begin
        if (inRange) begin
          mem[addr[idxW-1:0]] <= wrData;
        end
      end else begin
        rdData <= inRange ? mem[addr[idxW-1:0]] : '0;
      end
    end
  end

endmodule

// ==== verilog/dbgPkg.sv ====
package dbgPkg;

  localparam int dataWidth     = 64;
  localparam int wordAddrWidth = 29;

  // SPI flash command bytes
  localparam logic [7:0] flashCmdId    = 8'h9F;
  localparam logic [7:0] flashCmdRead3 = 8'h03;
  localparam logic [7:0] flashCmdRead4 = 8'h13;
  localparam logic [7:0] flashDummy    = 8'hFF;

  // JEDEC size codes above this need 4-byte addressing
  localparam logic [7:0] addr4bThreshold = 8'h18;

  // Writes in the low half, reads with bit 3 set
  typedef enum logic [3:0] {
    opCpuCtrlWr   = 4'h0,
    opMemDataWr   = 4'h2,
    opMemAddrWr   = 4'h3,
    opLoaderStart = 4'h4,
    opStatRd      = 4'h8,
    opInfoRd      = 4'h9,
    opMemDataRd   = 4'hA,
    opMemAddrRd   = 4'hB
  } dbgOp_t;

  typedef enum logic [4:0] {
    stIdle,
    stIdCmd,
    stIdMfr,
    stIdType,
    stIdSize,
    stRdCmd,
    stAddr3,
    stAddr2,
    stAddr1,
    stAddr0,
    stDataByte,
    stRomWr,
    stIncAddr,
    stDone
  } ldrState_t;

endpackage

// ==== verilog/debugRegs.sv ====
`timescale 1ns/1ps

module debugRegs import dbgPkg::*; #(
  parameter logic [7:0] mcuType = 8'h08,
  parameter logic [7:0] brdVers = 8'h05,
  parameter logic [7:0] coreCnt = 8'h02
) (
  input  logic                     clkH,
  input  logic                     reset,
  input  logic                     cmdValid,
  input  dbgOp_t                   cmdOp,
  input  logic [dataWidth-1:0]     cmdData,
  input  logic                     ldrActive,
  input  logic [7:0]               ldrSizeCode,
  input  logic                     memGnt,
  input  logic [dataWidth-1:0]     memRdData,
  output logic                     cmdReady,
  output logic                     rspValid,
  output logic [dataWidth-1:0]     rspData,
  output logic                     dbgExecEn,
  output logic                     dbgResetS,
  output logic                     dbgClkHEn,
  output logic                     ldrStart,
  output logic                     memReq,
  output logic                     memWrite,
  output logic [wordAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]     memWrData
);

  logic                     cmdFire;
  logic                     memPend;
  logic                     rdWait;
  logic [2:0]               ctrlBits;
  logic [wordAddrWidth-1:0] addrPtr;
  logic [dataWidth-1:0]     statWord;
  logic [dataWidth-1:0]     infoWord;
  logic [dataWidth-1:0]     addrWord;

  assign cmdReady = ~memPend & ~rdWait;
  assign cmdFire  = cmdValid & cmdReady;
  assign ldrStart = cmdFire & (cmdOp == opLoaderStart);

  assign {dbgExecEn, dbgResetS, dbgClkHEn} = ctrlBits;
  assign memReq  = memPend;
  assign memAddr = addrPtr;

  // ExecEn ResetS ClkHEn in the low bits
  assign statWord = {{(dataWidth-16){1'b0}}, ldrSizeCode, 3'b000, ldrActive, 1'b0, ctrlBits};
  assign infoWord = {{(dataWidth-24){1'b0}}, brdVers, mcuType, coreCnt};
  // Byte address of the current word
  assign addrWord = {{(dataWidth-wordAddrWidth-3){1'b0}}, addrPtr, 3'b000};

  always_ff @(posedge clkH) begin
    if (reset) begin
      ctrlBits <= '0;
      addrPtr  <= '0;
      memPend  <= 1'b0;
      memWrite <= 1'b0;
      rdWait   <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      rspValid <= 1'b0;
      if (cmdFire) begin
        case (cmdOp)
          opCpuCtrlWr: ctrlBits <= cmdData[2:0];
          opMemAddrWr: addrPtr <= cmdData[wordAddrWidth-1:0];
          opMemDataWr: begin
            memPend  <= 1'b1;
            memWrite <= 1'b1;
          end
          opMemDataRd: begin
            memPend  <= 1'b1;
            memWrite <= 1'b0;
          end
          opStatRd, opInfoRd, opMemAddrRd: rspValid <= 1'b1;
          default: ;
        endcase
      end
      if (memPend && memGnt) begin
        memPend <= 1'b0;
        addrPtr <= addrPtr + 1'b1;
        rdWait  <= ~memWrite;
      end
      // RAM data is on memRdData now
      if (rdWait) begin
        rdWait   <= 1'b0;
        rspValid <= 1'b1;
      end
    end
  end

  always_ff @(posedge clkH) begin
    if (cmdFire) begin
      case (cmdOp)
        opStatRd:    rspData <= statWord;
        opInfoRd:    rspData <= infoWord;
        opMemAddrRd: rspData <= addrWord;
        opMemDataWr: memWrData <= cmdData;
        default: ;
      endcase
    end
    if (rdWait) begin
      rspData <= memRdData;
    end
  end

endmodule

// ==== verilog/debugTop.sv ====
`timescale 1ns/1ps

module debugTop import dbgPkg::*; #(
  parameter int          romWords  = 16,
  parameter logic [31:0] flashBase = 32'h0000_1000,
  parameter int          spiDiv    = 2,
  parameter logic [7:0]  mcuType   = 8'h08,
  parameter logic [7:0]  brdVers   = 8'h05,
  parameter logic [7:0]  coreCnt   = 8'h02
) (
  input  logic                 clkH,
  input  logic                 reset,
  input  logic                 cmdValid,
  output logic                 cmdReady,
  input  dbgOp_t               cmdOp,
  input  logic [dataWidth-1:0] cmdData,
  output logic                 rspValid,
  output logic [dataWidth-1:0] rspData,
  output logic                 dbgExecEn,
  output logic                 dbgResetS,
  output logic                 dbgClkHEn,
  output logic                 spiSck,
  output logic                 spiMosi,
  input  logic                 spiMiso,
  output logic                 spiCsN
);

  logic                     ldrActive;
  logic [7:0]               ldrSizeCode;
  logic                     ldrStart;
  logic                     ldrLock;
  logic                     ldrReq;
  logic                     ldrWrite;
  logic [wordAddrWidth-1:0] ldrAddr;
  logic [dataWidth-1:0]     ldrWrData;
  logic                     ldrGnt;
  logic                     dbgReq;
  logic                     dbgWrite;
  logic [wordAddrWidth-1:0] dbgAddr;
  logic [dataWidth-1:0]     dbgWrData;
  logic                     dbgGnt;
  logic [dataWidth-1:0]     dbgRdData;
  logic                     ramEn;
  logic                     ramWrite;
  logic [wordAddrWidth-1:0] ramAddr;
  logic [dataWidth-1:0]     ramWrData;
  logic [dataWidth-1:0]     ramRdData;

  debugRegs #(
    .mcuType (mcuType),
    .brdVers (brdVers),
    .coreCnt (coreCnt)
  ) uRegs (
    .clkH        (clkH),
    .reset       (reset),
    .cmdValid    (cmdValid),
    .cmdOp       (cmdOp),
    .cmdData     (cmdData),
    .ldrActive   (ldrActive),
    .ldrSizeCode (ldrSizeCode),
    .memGnt      (dbgGnt),
    .memRdData   (dbgRdData),
    .cmdReady    (cmdReady),
    .rspValid    (rspValid),
    .rspData     (rspData),
    .dbgExecEn   (dbgExecEn),
    .dbgResetS   (dbgResetS),
    .dbgClkHEn   (dbgClkHEn),
    .ldrStart    (ldrStart),
    .memReq      (dbgReq),
    .memWrite    (dbgWrite),
    .memAddr     (dbgAddr),
    .memWrData   (dbgWrData)
  );

  flashLoader #(
    .romWords  (romWords),
    .flashBase (flashBase),
    .spiDiv    (spiDiv)
  ) uLoader (
    .clkH      (clkH),
    .reset     (reset),
    .start     (ldrStart),
    .memGnt    (ldrGnt),
    .spiMiso   (spiMiso),
    .active    (ldrActive),
    .sizeCode  (ldrSizeCode),
    .memLock   (ldrLock),
    .memReq    (ldrReq),
    .memWrite  (ldrWrite),
    .memAddr   (ldrAddr),
    .memWrData (ldrWrData),
    .spiSck    (spiSck),
    .spiMosi   (spiMosi),
    .spiCsN    (spiCsN)
  );

  memArbiter uArbiter (
    .clkH      (clkH),
    .reset     (reset),
    .ldrReq    (ldrReq),
    .ldrLock   (ldrLock),
    .ldrWrite  (ldrWrite),
    .ldrAddr   (ldrAddr),
    .ldrWrData (ldrWrData),
    .dbgReq    (dbgReq),
    .dbgWrite  (dbgWrite),
    .dbgAddr   (dbgAddr),
    .dbgWrData (dbgWrData),
    .ramRdData (ramRdData),
    .ldrGnt    (ldrGnt),
    .dbgGnt    (dbgGnt),
    .ramEn     (ramEn),
    .ramWrite  (ramWrite),
    .ramAddr   (ramAddr),
    .ramWrData (ramWrData),
    .dbgRdData (dbgRdData)
  );

  bootRam #(
    .romWords (romWords)
  ) uBootRam (
    .clkH   (clkH),
    .en     (ramEn),
    .write  (ramWrite),
    .addr   (ramAddr),
    .wrData (ramWrData),
    .rdData (ramRdData)
  );

endmodule

// ==== verilog/flashLoader.sv ====
`timescale 1ns/1ps

module flashLoader import dbgPkg::*; #(
  parameter int          romWords  = 16,
  parameter logic [31:0] flashBase = 32'h0000_0000,
  parameter int          spiDiv    = 2
) (
  input  logic                     clkH,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     memGnt,
  input  logic                     spiMiso,
  output logic                     active,
  output logic [7:0]               sizeCode,
  output logic                     memLock,
  output logic                     memReq,
  output logic                     memWrite,
  output logic [wordAddrWidth-1:0] memAddr,
  output logic [dataWidth-1:0]     memWrData,
  output logic                     spiSck,
  output logic                     spiMosi,
  output logic                     spiCsN
);

  localparam int wordCntW = (romWords > 1) ? $clog2(romWords) : 1;

  ldrState_t            state;
  logic                 sent;
  logic [2:0]           byteIdx;
  logic [wordCntW-1:0]  wordIdx;
  logic [dataWidth-1:0] wordData;
  logic                 addr4b;
  logic                 lastWord;
  logic                 sendState;
  logic                 spiCs;
  logic                 spiSendValid;
  logic                 spiSendReady;
  logic [7:0]           spiSendByte;
  logic                 spiRecvValid;
  logic [7:0]           spiRecvByte;

  assign addr4b   = (sizeCode > addr4bThreshold);
  assign lastWord = (wordIdx == wordCntW'(romWords - 1));

  assign active    = (state != stIdle);
  assign memLock   = (state != stIdle);
  assign memReq    = (state == stRomWr);
  assign memWrite  = (state == stRomWr);
  assign memAddr   = wordAddrWidth'(wordIdx);
  assign memWrData = wordData;

  // Byte to send in each SPI state
  always_comb begin
    sendState   = 1'b0;
    spiSendByte = flashDummy;
    case (state)
      stIdCmd: begin
        sendState   = 1'b1;
        spiSendByte = flashCmdId;
      end
      stIdMfr, stIdType, stIdSize, stDataByte: begin
        sendState = 1'b1;
      end
      stRdCmd: begin
        // Wait out the CS gap first
        sendState   = spiCs;
        spiSendByte = addr4b ? flashCmdRead4 : flashCmdRead3;
      end
      stAddr3: begin
        sendState   = 1'b1;
        spiSendByte = flashBase[31:24];
      end
      stAddr2: begin
        sendState   = 1'b1;
        spiSendByte = flashBase[23:16];
      end
      stAddr1: begin
        sendState   = 1'b1;
        spiSendByte = flashBase[15:8];
      end
      stAddr0: begin
        sendState   = 1'b1;
        spiSendByte = flashBase[7:0];
      end
      default: ;
    endcase
  end

  assign spiSendValid = sendState & ~sent;

  always_ff @(posedge clkH) begin
    if (reset) begin
      state    <= stIdle;
      sent     <= 1'b0;
      spiCs    <= 1'b0;
      byteIdx  <= '0;
      wordIdx  <= '0;
      sizeCode <= '0;
    end else begin
      if (spiSendValid && spiSendReady) begin
        sent <= 1'b1;
      end
      if (spiRecvValid) begin
        sent <= 1'b0;
      end
      case (state)
        stIdle: begin
          if (start) begin
            state   <= stIdCmd;
            spiCs   <= 1'b1;
            byteIdx <= '0;
            wordIdx <= '0;
          end
        end
        stIdCmd: if (spiRecvValid) state <= stIdMfr;
        stIdMfr: if (spiRecvValid) state <= stIdType;
        stIdType: if (spiRecvValid) state <= stIdSize;
        stIdSize: begin
          if (spiRecvValid) begin
            sizeCode <= spiRecvByte;
            spiCs    <= 1'b0;
            state    <= stRdCmd;
          end
        end
        stRdCmd: begin
          spiCs <= 1'b1;
          if (spiRecvValid) begin
            state <= addr4b ? stAddr3 : stAddr2;
          end
        end
        stAddr3: if (spiRecvValid) state <= stAddr2;
        stAddr2: if (spiRecvValid) state <= stAddr1;
        stAddr1: if (spiRecvValid) state <= stAddr0;
        stAddr0: if (spiRecvValid) state <= stDataByte;
        stDataByte: begin
          if (spiRecvValid) begin
            byteIdx <= byteIdx + 3'd1;
            if (byteIdx == 3'd7) begin
              state <= stRomWr;
              if (lastWord) begin
                spiCs <= 1'b0;
              end
            end
          end
        end
        stRomWr: if (memGnt) state <= stIncAddr;
        stIncAddr: begin
          if (lastWord) begin
            state <= stDone;
          end else begin
            wordIdx <= wordIdx + 1'b1;
            state   <= stDataByte;
          end
        end
        stDone: state <= stIdle;
        default: state <= stIdle;
      endcase
    end
  end

  // First flash byte ends up in the lowest byte
  always_ff @(posedge clkH) begin
    if (state == stDataByte && spiRecvValid) begin
      wordData <= {spiRecvByte, wordData[dataWidth-1:8]};
    end
  end

  spiByteEngine #(
    .spiDiv(spiDiv)
  ) uSpiEngine (
    .clkH      (clkH),
    .reset     (reset),
    .sendValid (spiSendValid),
    .sendByte  (spiSendByte),
    .miso      (spiMiso),
    .cs        (spiCs),
    .sendReady (spiSendReady),
    .recvValid (spiRecvValid),
    .recvByte  (spiRecvByte),
    .sck       (spiSck),
    .mosi      (spiMosi),
    .csN       (spiCsN)
  );

endmodule

// ==== verilog/memArbiter.sv ====
`timescale 1ns/1ps

module memArbiter import dbgPkg::*; (
  input  logic                     clkH,
  input  logic                     reset,
  input  logic                     ldrReq,
  input  logic                     ldrLock,
  input  logic                     ldrWrite,
  input  logic [wordAddrWidth-1:0] ldrAddr,
  input  logic [dataWidth-1:0]     ldrWrData,
  input  logic                     dbgReq,
  input  logic                     dbgWrite,
  input  logic [wordAddrWidth-1:0] dbgAddr,
  input  logic [dataWidth-1:0]     dbgWrData,
  input  logic [dataWidth-1:0]     ramRdData,
  output logic                     ldrGnt,
  output logic                     dbgGnt,
  output logic                     ramEn,
  output logic                     ramWrite,
  output logic [wordAddrWidth-1:0] ramAddr,
  output logic [dataWidth-1:0]     ramWrData,
  output logic [dataWidth-1:0]     dbgRdData
);

  logic dbgRdOwn;

  // Loader first, debug shut out for the whole copy
  assign ldrGnt = ldrReq;
  assign dbgGnt = dbgReq & ~ldrReq & ~ldrLock;

  assign ramEn     = ldrGnt | dbgGnt;
  assign ramWrite  = ldrGnt ? ldrWrite : (dbgGnt & dbgWrite);
  assign ramAddr   = ldrGnt ? ldrAddr : dbgAddr;
  assign ramWrData = ldrGnt ? ldrWrData : dbgWrData;

  assign dbgRdData = dbgRdOwn ? ramRdData : '0;

  always_ff @(posedge clkH) begin
    if (reset) begin
      dbgRdOwn <= 1'b0;
    end else begin
      dbgRdOwn <= dbgGnt & ~dbgWrite;
    end
  end

endmodule

// ==== verilog/spiByteEngine.sv ====
`timescale 1ns/1ps

module spiByteEngine #(
  parameter int spiDiv = 2
) (
  input  logic       clkH,
  input  logic       reset,
  input  logic       sendValid,
  input  logic [7:0] sendByte,
  input  logic       miso,
  input  logic       cs,
  output logic       sendReady,
  output logic       recvValid,
  output logic [7:0] recvByte,
  output logic       sck,
  output logic       mosi,
  output logic       csN
);

  localparam int divW = (spiDiv > 1) ? $clog2(spiDiv) : 1;

  logic            busy;
  logic [divW-1:0] divCnt;
  logic [2:0]      bitCnt;
  logic [7:0]      shiftOut;
  logic [7:0]      shiftIn;
  logic            halfDone;

  // End of one SCK half-period
  assign halfDone  = (divCnt == divW'(spiDiv - 1));
  assign sendReady = ~busy;
  assign mosi      = shiftOut[7];
  assign recvByte  = shiftIn;

  always_ff @(posedge clkH) begin
    if (reset) begin
      busy      <= 1'b0;
      divCnt    <= '0;
      bitCnt    <= '0;
      sck       <= 1'b0;
      recvValid <= 1'b0;
      csN       <= 1'b1;
    end else begin
      csN       <= ~cs;
      recvValid <= 1'b0;
      if (!busy) begin
        if (sendValid) begin
          busy   <= 1'b1;
          divCnt <= '0;
          bitCnt <= '0;
        end
      end else if (halfDone) begin
        divCnt <= '0;
        sck    <= ~sck;
        // Falling edge closes a bit
        if (sck) begin
          bitCnt <= bitCnt + 3'd1;
          if (bitCnt == 3'd7) begin
            busy      <= 1'b0;
            recvValid <= 1'b1;
          end
        end
      end else begin
        divCnt <= divCnt + 1'b1;
      end
    end
  end

  // Sample on rising SCK, shift out on falling
  always_ff @(posedge clkH) begin
    if (!busy && sendValid) begin
      shiftOut <= sendByte;
    end else if (busy && halfDone) begin
      if (sck) begin
        shiftOut <= {shiftOut[6:0], 1'b0};
      end else begin
        shiftIn <= {shiftIn[6:0], miso};
      end
    end
  end

endmodule
